// ==== common/stk_macros.svh ====
// -----------------------------------------------
// Sizing for the stack admission stage
// Queue depth must be a power of two, at least 2
// -----------------------------------------------

`ifndef STK_MACROS_SVH
`define STK_MACROS_SVH

// Number of command engines
// Engine ids are $clog2 of this wide
`define STK_ENGS_N 4

// Width of a PUSH data word
`define STK_DAT_W 128

// Entries in each of the push and pop queues
// Two is enough to cover the registered full flag
`define STK_Q_DEPTH 2

`endif

// ==== common/stk_cmd_pkg.sv ====
// -----------------------------------------------
// Command-side types seen by the engines
// -----------------------------------------------

`include "stk_macros.svh"

package stk_cmd_pkg;

  // Engine command opcode
  // Value 3 is reserved and never acknowledged
  typedef enum logic [1:0] {
    OP_NOP  = 2'd0,
    OP_PUSH = 2'd1,
    OP_POP  = 2'd2,
    OP_RSVD = 2'd3
  } opcode_t;

  // Engine id
  typedef logic [$clog2(`STK_ENGS_N)-1:0] engid_t;

  // PUSH payload
  typedef logic [`STK_DAT_W-1:0] cmd_dat_t;

  // Push-queue word, id in the upper bits
  typedef struct packed {
    engid_t   engid;
    cmd_dat_t dat;
  } push_entry_t;

endpackage : stk_cmd_pkg

// ==== common/stk_issue_pkg.sv ====
// -----------------------------------------------
// Issue-side types toward the LK stage
// -----------------------------------------------

`include "stk_macros.svh"

package stk_issue_pkg;

  // One bit per engine
  // Request and grant vectors, and the active set
  typedef logic [`STK_ENGS_N-1:0] eng_vec_t;

  // LK opcode, only PUSH and POP reach issue
  // Encoding tracks the engine-side opcode
  typedef enum logic [1:0] {
    LK_PUSH = 2'(stk_cmd_pkg::OP_PUSH),
    LK_POP  = 2'(stk_cmd_pkg::OP_POP)
  } lk_op_t;

endpackage : stk_issue_pkg

// ==== common/stk_enq_if.sv ====
// -----------------------------------------------
// Admission to queue write side
// Writes are strobes, one queue per cycle at most
// -----------------------------------------------

`timescale 1ns/10ps

interface stk_enq_if;

  // Write strobes and the shared write payload
  logic                  push_wr;
  logic                  pop_wr;
  stk_cmd_pkg::engid_t   wr_engid;
  // Only the push queue stores data
  stk_cmd_pkg::cmd_dat_t wr_dat;

  // Registered full flags back to admission
  logic                  push_full;
  logic                  pop_full;

  modport admit (
    output push_wr, pop_wr, wr_engid, wr_dat,
    input  push_full, pop_full
  );

  modport queue_side (
    input  push_wr, pop_wr, wr_engid, wr_dat,
    output push_full, pop_full
  );

endinterface : stk_enq_if

// ==== common/stk_head_if.sv ====
// -----------------------------------------------
// Queue heads to issue
// Heads are only meaningful while nempty is high
// -----------------------------------------------

`timescale 1ns/10ps

interface stk_head_if;

  // Push queue head
  logic                     push_nempty;
  stk_cmd_pkg::push_entry_t push_head;

  // Pop queue head, id only
  logic                     pop_nempty;
  stk_cmd_pkg::engid_t      pop_head;

  // Dequeue strobes from issue
  logic                     push_deq;
  logic                     pop_deq;

  modport issue (
    input  push_nempty, push_head, pop_nempty, pop_head,
    output push_deq, pop_deq
  );

  modport queue_side (
    output push_nempty, push_head, pop_nempty, pop_head,
    input  push_deq, pop_deq
  );

endinterface : stk_head_if

// ==== verilog/stk_rr_arb.sv ====
// -----------------------------------------------
// Round-robin arbiter, combinational grant
// Pointer moves only on i_ack, ack needs a grant
// -----------------------------------------------

`timescale 1ns/10ps

module stk_rr_arb #(
  parameter int W = 4
) (
  input  logic [W-1:0] i_req
, input  logic         i_ack
, output logic [W-1:0] o_gnt
, input  logic         clk
, input  logic         i_rst_n
);

  localparam int IDX_W = (W > 1) ? $clog2(W) : 1;

  // Highest-priority requester this cycle
  logic [IDX_W-1:0] ptr;
  logic [IDX_W-1:0] gnt_idx;

  // Scan from ptr around the ring, first hit wins
  always_comb begin : rr_pick
    int   idx;
    logic found;
    o_gnt   = '0;
    gnt_idx = '0;
    found   = 1'b0;
    for (int i = 0; i < W; i++) begin
      idx = (int'(ptr) + i) % W;
      if (i_req[idx] && !found) begin
        o_gnt[idx] = 1'b1;
        gnt_idx    = IDX_W'(idx);
        found      = 1'b1;
      end
    end
  end

  // Priority passes to the one after the winner
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ptr <= '0;
    end else if (i_ack) begin
      ptr <= (gnt_idx == IDX_W'(W - 1)) ? '0 : gnt_idx + 1'b1;
    end
  end

endmodule : stk_rr_arb

// ==== verilog/stk_cmd_queue.sv ====
// -----------------------------------------------
// Register-file FIFO, DEPTH a power of two >= 2
// Head shows a write one cycle later
// -----------------------------------------------

`timescale 1ns/10ps

module stk_cmd_queue #(
  parameter int DEPTH = 2
, parameter int W     = 8
) (
  input  logic         i_push
, input  logic [W-1:0] i_push_dat
, input  logic         i_pop
, output logic [W-1:0] o_pop_dat
, output logic         o_full
, output logic         o_empty
, input  logic         clk
, input  logic         i_rst_n
);

  localparam int AW = $clog2(DEPTH);

  // Storage
  logic [W-1:0] mem [DEPTH];

  // Pointers carry one extra wrap bit
  logic [AW:0]  wr_ptr;
  logic [AW:0]  rd_ptr;
  logic [AW:0]  wr_ptr_nxt;
  logic [AW:0]  rd_ptr_nxt;
  logic         push_ok;
  logic         pop_ok;
  logic         full_nxt;
  logic         empty_nxt;

  // Drop strobes that would overrun or underrun
  assign push_ok = i_push & ~o_full;
  assign pop_ok  = i_pop & ~o_empty;

  assign wr_ptr_nxt = wr_ptr + {{AW{1'b0}}, push_ok};
  assign rd_ptr_nxt = rd_ptr + {{AW{1'b0}}, pop_ok};

  // Flags from the next pointer state
  assign empty_nxt = (wr_ptr_nxt == rd_ptr_nxt);
  assign full_nxt  = (wr_ptr_nxt[AW] != rd_ptr_nxt[AW])
                   && (wr_ptr_nxt[AW-1:0] == rd_ptr_nxt[AW-1:0]);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_full  <= 1'b0;
      o_empty <= 1'b1;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      rd_ptr  <= rd_ptr_nxt;
      o_full  <= full_nxt;
      o_empty <= empty_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr[AW-1:0]] <= i_push_dat;
    end
  end

  // Head entry
  assign o_pop_dat = mem[rd_ptr[AW-1:0]];

endmodule : stk_cmd_queue

// ==== admit/stk_admit.sv ====
// -----------------------------------------------
// Command admission, fully combinational
// Engines hold a command until their ack bit
// -----------------------------------------------

`timescale 1ns/10ps

`include "stk_macros.svh"

module stk_admit (
  input  stk_cmd_pkg::opcode_t  [`STK_ENGS_N-1:0] i_cmd_opcode
, input  stk_cmd_pkg::cmd_dat_t [`STK_ENGS_N-1:0] i_cmd_dat
, output stk_issue_pkg::eng_vec_t                 o_cmd_ack
, stk_enq_if.admit                                enq
, input  logic                                    clk
, input  logic                                    i_rst_n
);

  stk_issue_pkg::eng_vec_t cmd_is_push;
  stk_issue_pkg::eng_vec_t cmd_is_pop;
  stk_issue_pkg::eng_vec_t enq_req;
  stk_issue_pkg::eng_vec_t enq_gnt;
  stk_cmd_pkg::engid_t     gnt_engid;
  stk_cmd_pkg::cmd_dat_t   gnt_dat;
  logic                    enq_ack;

  // Per-engine decode, NOP and reserved fall out here
  for (genvar e = 0; e < `STK_ENGS_N; e++) begin : g_dec
    assign cmd_is_push[e] = (i_cmd_opcode[e] == stk_cmd_pkg::OP_PUSH);
    assign cmd_is_pop[e]  = (i_cmd_opcode[e] == stk_cmd_pkg::OP_POP);
  end

  // A full queue masks requests of its opcode
  assign enq_req = (cmd_is_push & {`STK_ENGS_N{~enq.push_full}})
                 | (cmd_is_pop  & {`STK_ENGS_N{~enq.pop_full}});

  stk_rr_arb #(.W(`STK_ENGS_N)) u_rr_enq (
    .i_req   (enq_req)
  , .i_ack   (enq_ack)
  , .o_gnt   (enq_gnt)
  , .clk     (clk)
  , .i_rst_n (i_rst_n)
  );

  // One-hot grant to id, plus the winner's data
  always_comb begin
    gnt_engid = '0;
    gnt_dat   = '0;
    for (int e = 0; e < `STK_ENGS_N; e++) begin
      if (enq_gnt[e]) begin
        gnt_engid = stk_cmd_pkg::engid_t'(e);
        gnt_dat   = i_cmd_dat[e];
      end
    end
  end

  // Write strobe follows the winner's opcode
  assign enq.push_wr  = |(enq_gnt & cmd_is_push);
  assign enq.pop_wr   = |(enq_gnt & cmd_is_pop);
  assign enq.wr_engid = gnt_engid;
  assign enq.wr_dat   = gnt_dat;

  // Any queue write is the acknowledge
  assign enq_ack   = enq.push_wr | enq.pop_wr;
  assign o_cmd_ack = enq_gnt & {`STK_ENGS_N{enq_ack}};

endmodule : stk_admit

// ==== issue/stk_issue.sv ====
// -----------------------------------------------
// Issue to LK, one command per cycle at most
// An engine stays blocked until its writeback
// -----------------------------------------------

`timescale 1ns/10ps

`include "stk_macros.svh"

module stk_issue (
  stk_head_if.issue               head
, input  logic                    i_al_empty
, input  logic                    i_al_busy
, input  logic                    i_wrbk_vld
, input  stk_cmd_pkg::engid_t     i_wrbk_engid
, output logic                    o_lk_vld
, output stk_cmd_pkg::engid_t     o_lk_engid
, output stk_issue_pkg::lk_op_t   o_lk_opcode
, output logic                    o_lk_dat_vld
, output stk_cmd_pkg::cmd_dat_t   o_lk_dat
, output logic                    o_al_alloc
, input  logic                    clk
, input  logic                    i_rst_n
);

  // Arbiter slots
  localparam int Q_PUSH = 0;
  localparam int Q_POP  = 1;

  stk_issue_pkg::eng_vec_t active_q;
  stk_issue_pkg::eng_vec_t active_set;
  stk_issue_pkg::eng_vec_t active_clr;
  stk_issue_pkg::eng_vec_t push_head_dec;
  stk_issue_pkg::eng_vec_t pop_head_dec;
  stk_issue_pkg::eng_vec_t lk_engid_dec;
  stk_issue_pkg::eng_vec_t wrbk_dec;
  logic [1:0]              deq_req;
  logic [1:0]              deq_gnt;
  logic                    deq_ack;

  // Head ids as one-hot
  assign push_head_dec = stk_issue_pkg::eng_vec_t'(1) << head.push_head.engid;
  assign pop_head_dec  = stk_issue_pkg::eng_vec_t'(1) << head.pop_head;

  // PUSH also needs a free line
  assign deq_req[Q_PUSH] = head.push_nempty & ~i_al_empty & ~|(active_q & push_head_dec);
  assign deq_req[Q_POP]  = head.pop_nempty & ~|(active_q & pop_head_dec);

  // Busy allocator stalls both queues
  assign deq_ack = ~i_al_busy & |deq_req;

  stk_rr_arb #(.W(2)) u_rr_deq (
    .i_req   (deq_req)
  , .i_ack   (deq_ack)
  , .o_gnt   (deq_gnt)
  , .clk     (clk)
  , .i_rst_n (i_rst_n)
  );

  assign head.push_deq = deq_ack & deq_gnt[Q_PUSH];
  assign head.pop_deq  = deq_ack & deq_gnt[Q_POP];

  // LK microcode
  assign o_lk_vld     = deq_ack;
  assign o_lk_engid   = deq_gnt[Q_PUSH] ? head.push_head.engid : head.pop_head;
  assign o_lk_opcode  = deq_gnt[Q_PUSH] ? stk_issue_pkg::LK_PUSH : stk_issue_pkg::LK_POP;
  assign o_lk_dat_vld = o_lk_vld & (o_lk_opcode == stk_issue_pkg::LK_PUSH);
  assign o_lk_dat     = head.push_head.dat;

  // Every issued PUSH claims a line
  assign o_al_alloc = o_lk_vld & (o_lk_opcode == stk_issue_pkg::LK_PUSH);

  // Set on issue, clear on writeback
  assign lk_engid_dec = stk_issue_pkg::eng_vec_t'(1) << o_lk_engid;
  assign wrbk_dec     = stk_issue_pkg::eng_vec_t'(1) << i_wrbk_engid;
  assign active_set   = lk_engid_dec & {`STK_ENGS_N{o_lk_vld}};
  assign active_clr   = wrbk_dec & {`STK_ENGS_N{i_wrbk_vld}};

  // Clear beats set on the same edge
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      active_q <= '0;
    end else begin
      active_q <= (active_q | active_set) & ~active_clr;
    end
  end

endmodule : stk_issue

// ==== verilog/stk_pipe_ad.sv ====
// -----------------------------------------------
// Stack admission top, earliest issue 1 cycle
// after ack; per-engine order holds per queue
// -----------------------------------------------

`timescale 1ns/10ps

`include "stk_macros.svh"

module stk_pipe_ad (
  input  stk_cmd_pkg::opcode_t  [`STK_ENGS_N-1:0] i_cmd_opcode
, input  stk_cmd_pkg::cmd_dat_t [`STK_ENGS_N-1:0] i_cmd_dat
, output stk_issue_pkg::eng_vec_t                 o_cmd_ack
, output logic                                    o_lk_vld
, output stk_cmd_pkg::engid_t                     o_lk_engid
, output stk_issue_pkg::lk_op_t                   o_lk_opcode
, output logic                                    o_lk_dat_vld
, output stk_cmd_pkg::cmd_dat_t                   o_lk_dat
, input  logic                                    i_al_empty
, input  logic                                    i_al_busy
, output logic                                    o_al_alloc
, input  logic                                    i_wrbk_vld
, input  stk_cmd_pkg::engid_t                     i_wrbk_engid
, input  logic                                    clk
, input  logic                                    i_rst_n
);

  stk_enq_if  u_enq_if ();
  stk_head_if u_head_if ();

  stk_cmd_pkg::push_entry_t qpush_wr_ent;
  logic                     qpush_empty;
  logic                     qpop_empty;

  stk_admit u_admit (
    .i_cmd_opcode (i_cmd_opcode)
  , .i_cmd_dat    (i_cmd_dat)
  , .o_cmd_ack    (o_cmd_ack)
  , .enq          (u_enq_if.admit)
  , .clk          (clk)
  , .i_rst_n      (i_rst_n)
  );

  // Push queue keeps id and data together
  assign qpush_wr_ent = '{engid: u_enq_if.wr_engid, dat: u_enq_if.wr_dat};

  stk_cmd_queue #(
    .DEPTH (`STK_Q_DEPTH)
  , .W     ($bits(stk_cmd_pkg::push_entry_t))
  ) u_qpush (
    .i_push     (u_enq_if.push_wr)
  , .i_push_dat (qpush_wr_ent)
  , .i_pop      (u_head_if.push_deq)
  , .o_pop_dat  (u_head_if.push_head)
  , .o_full     (u_enq_if.push_full)
  , .o_empty    (qpush_empty)
  , .clk        (clk)
  , .i_rst_n    (i_rst_n)
  );

  // Pop queue needs only the id
  stk_cmd_queue #(
    .DEPTH (`STK_Q_DEPTH)
  , .W     ($bits(stk_cmd_pkg::engid_t))
  ) u_qpop (
    .i_push     (u_enq_if.pop_wr)
  , .i_push_dat (u_enq_if.wr_engid)
  , .i_pop      (u_head_if.pop_deq)
  , .o_pop_dat  (u_head_if.pop_head)
  , .o_full     (u_enq_if.pop_full)
  , .o_empty    (qpop_empty)
  , .clk        (clk)
  , .i_rst_n    (i_rst_n)
  );

  assign u_head_if.push_nempty = ~qpush_empty;
  assign u_head_if.pop_nempty  = ~qpop_empty;

  stk_issue u_issue (
    .head         (u_head_if.issue)
  , .i_al_empty   (i_al_empty)
  , .i_al_busy    (i_al_busy)
  , .i_wrbk_vld   (i_wrbk_vld)
  , .i_wrbk_engid (i_wrbk_engid)
  , .o_lk_vld     (o_lk_vld)
  , .o_lk_engid   (o_lk_engid)
  , .o_lk_opcode  (o_lk_opcode)
  , .o_lk_dat_vld (o_lk_dat_vld)
  , .o_lk_dat     (o_lk_dat)
  , .o_al_alloc   (o_al_alloc)
  , .clk          (clk)
  , .i_rst_n      (i_rst_n)
  );

endmodule : stk_pipe_ad

// ==== sim/stk_pipe_ad_sva.sv ====
// --------------------------------------------------
// Protocol checks bound onto the admission top
// --------------------------------------------------

`timescale 1ns/10ps

module stk_pipe_ad_sva (
  input  logic                    clk
, input  logic                    i_rst_n
, input  stk_issue_pkg::eng_vec_t o_cmd_ack
, input  logic                    o_lk_vld
, input  stk_issue_pkg::lk_op_t   o_lk_opcode
, input  logic                    o_lk_dat_vld
, input  logic                    o_al_alloc
, input  logic                    i_al_busy
);

  // At most one engine acknowledged per cycle
  a_ack_onehot : assert property (@(posedge clk) disable iff (!i_rst_n)
    $onehot0(o_cmd_ack))
    else $error("o_cmd_ack has more than one bit set");

  // Busy allocator stalls all issue
  a_busy_stall : assert property (@(posedge clk) disable iff (!i_rst_n)
    i_al_busy |-> !o_lk_vld)
    else $error("o_lk_vld high while i_al_busy is high");

  // Line claimed exactly on an issued PUSH
  a_alloc_push : assert property (@(posedge clk) disable iff (!i_rst_n)
    o_al_alloc == (o_lk_vld && o_lk_opcode == stk_issue_pkg::LK_PUSH))
    else $error("o_al_alloc does not match an issued PUSH");

  a_pop_no_dat : assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_lk_opcode == stk_issue_pkg::LK_POP) |-> !o_lk_dat_vld)
    else $error("o_lk_dat_vld high on a POP");

endmodule : stk_pipe_ad_sva

bind stk_pipe_ad stk_pipe_ad_sva u_sva (
  .clk          (clk)
, .i_rst_n      (i_rst_n)
, .o_cmd_ack    (o_cmd_ack)
, .o_lk_vld     (o_lk_vld)
, .o_lk_opcode  (o_lk_opcode)
, .o_lk_dat_vld (o_lk_dat_vld)
, .o_al_alloc   (o_al_alloc)
, .i_al_busy    (i_al_busy)
);

// ==== sim/stk_pipe_ad_tb.sv ====
// --------------------------------------------------
// Testbench for the stack admission top
// Queue full flags are modeled from ack/issue counts
// --------------------------------------------------

`timescale 1ns/10ps

`include "stk_macros.svh"

module stk_pipe_ad_tb;

  localparam int ENGS      = `STK_ENGS_N;
  localparam int DAT_W     = `STK_DAT_W;
  localparam int RST_CYC   = 10;
  // Commands over all tests, and cycles allowed per command
  localparam int TOTAL_CMD = 1 + 1 + 2 * 6 + ENGS * 24 + ENGS * 6;
  localparam int WDOG_MULT = 40;
  localparam int ALL_ENG   = (1 << ENGS) - 1;

  // Engine stimulus modes
  localparam int M_IDLE = 0;
  localparam int M_PUSH = 1;
  localparam int M_POP  = 2;
  localparam int M_MIX  = 3;

  logic                               clk;
  logic                               i_rst_n;
  stk_cmd_pkg::opcode_t  [ENGS-1:0]   i_cmd_opcode;
  stk_cmd_pkg::cmd_dat_t [ENGS-1:0]   i_cmd_dat;
  stk_issue_pkg::eng_vec_t            o_cmd_ack;
  logic                               o_lk_vld;
  stk_cmd_pkg::engid_t                o_lk_engid;
  stk_issue_pkg::lk_op_t              o_lk_opcode;
  logic                               o_lk_dat_vld;
  stk_cmd_pkg::cmd_dat_t              o_lk_dat;
  logic                               i_al_empty;
  logic                               i_al_busy;
  logic                               o_al_alloc;
  logic                               i_wrbk_vld;
  stk_cmd_pkg::engid_t                i_wrbk_engid;

  // Reference state, {opcode, data} acked but not yet issued
  logic [DAT_W+1:0]        pend_q [ENGS][$];
  logic [15:0]             lfsr_q;
  int                      push_occ;
  int                      pop_occ;
  stk_issue_pkg::eng_vec_t tb_active;
  logic [ENGS-1:0]         ack_seen;
  logic [ENGS-1:0]         holding;
  int                      cmd_left [ENGS];
  int                      wb_cnt [ENGS];
  int                      wait_cnt [ENGS];
  int                      err_cnt;
  int                      ack_cnt;
  int                      issue_cnt;

  stk_pipe_ad dut (
    .i_cmd_opcode (i_cmd_opcode)
  , .i_cmd_dat    (i_cmd_dat)
  , .o_cmd_ack    (o_cmd_ack)
  , .o_lk_vld     (o_lk_vld)
  , .o_lk_engid   (o_lk_engid)
  , .o_lk_opcode  (o_lk_opcode)
  , .o_lk_dat_vld (o_lk_dat_vld)
  , .o_lk_dat     (o_lk_dat)
  , .i_al_empty   (i_al_empty)
  , .i_al_busy    (i_al_busy)
  , .o_al_alloc   (o_al_alloc)
  , .i_wrbk_vld   (i_wrbk_vld)
  , .i_wrbk_engid (i_wrbk_engid)
  , .clk          (clk)
  , .i_rst_n      (i_rst_n)
  );

  always #5 clk = ~clk;

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [DAT_W-1:0] rand_bits(input int n);
    logic [DAT_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[DAT_W-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Expected LK view {opcode, dat_vld, alloc, data}
  // Opcode passes through, only PUSH carries data and claims a line
  function automatic logic [DAT_W+3:0] ref_issue(input logic [DAT_W+1:0] ent);
    logic is_push;
    is_push = (ent[DAT_W+1:DAT_W] == 2'(stk_cmd_pkg::OP_PUSH));
    return {ent[DAT_W+1:DAT_W], is_push, is_push, is_push ? ent[DAT_W-1:0] : DAT_W'(0)};
  endfunction

  function automatic logic all_idle();
    logic idle;
    idle = (tb_active == '0) && !i_wrbk_vld;
    for (int k = 0; k < ENGS; k++) begin
      idle = idle && (cmd_left[k] == 0) && !holding[k] && (pend_q[k].size() == 0);
    end
    return idle;
  endfunction

  // Compare at the falling edge, inputs and outputs are settled
  always @(negedge clk) begin : compare
    stk_issue_pkg::eng_vec_t req;
    logic [DAT_W+3:0]        exp_v;
    logic [DAT_W+1:0]        ent;
    int                      e;
    if (i_rst_n) begin
      // An engine requests with PUSH or POP while its queue has room
      for (int k = 0; k < ENGS; k++) begin
        req[k] = (i_cmd_opcode[k] == stk_cmd_pkg::OP_PUSH && push_occ < `STK_Q_DEPTH)
              || (i_cmd_opcode[k] == stk_cmd_pkg::OP_POP && pop_occ < `STK_Q_DEPTH);
      end
      assert ((o_cmd_ack & ~req) == '0 && ((o_cmd_ack != '0) == (req != '0)))
        else begin
          $display("FAIL o_cmd_ack=%h with requests %h", o_cmd_ack, req);
          err_cnt++;
        end
      for (int k = 0; k < ENGS; k++) begin
        // Acks to others while this engine keeps requesting
        if (!req[k] || o_cmd_ack[k]) begin
          wait_cnt[k] = 0;
        end else if (o_cmd_ack != '0) begin
          wait_cnt[k]++;
        end
        assert (wait_cnt[k] <= ENGS)
          else begin
            $display("engine %0d waited for more than %0d acknowledges", k, ENGS);
            err_cnt++;
          end
        if (o_cmd_ack[k]) begin
          pend_q[k].push_back({i_cmd_opcode[k], i_cmd_dat[k]});
          if (i_cmd_opcode[k] == stk_cmd_pkg::OP_PUSH) begin
            push_occ++;
          end else begin
            pop_occ++;
          end
          ack_seen[k] = 1'b1;
          ack_cnt++;
        end
      end
      assert (o_lk_vld || (!o_lk_dat_vld && !o_al_alloc))
        else begin
          $display("data valid or allocation strobe without an issue");
          err_cnt++;
        end
      if (o_lk_vld) begin
        e = int'(o_lk_engid);
        issue_cnt++;
        assert (!tb_active[e] && !i_al_busy)
          else begin
            $display("engine %0d issued while in flight or allocator busy", e);
            err_cnt++;
          end
        assert (pend_q[e].size() > 0)
          else begin
            $display("engine %0d issued with no acknowledged command", e);
            err_cnt++;
          end
        if (pend_q[e].size() > 0) begin
          ent   = pend_q[e].pop_front();
          exp_v = ref_issue(ent);
          assert (o_lk_opcode == exp_v[DAT_W+3:DAT_W+2])
            else begin
              $display("FAIL o_lk_opcode=%h expected %h", o_lk_opcode, exp_v[DAT_W+3:DAT_W+2]);
              err_cnt++;
            end
          assert ({o_lk_dat_vld, o_al_alloc} == exp_v[DAT_W+1:DAT_W])
            else begin
              $display("FAIL {o_lk_dat_vld,o_al_alloc}=%h expected %h",
                       {o_lk_dat_vld, o_al_alloc}, exp_v[DAT_W+1:DAT_W]);
              err_cnt++;
            end
          assert (!exp_v[DAT_W] || (o_lk_dat == exp_v[DAT_W-1:0] && !i_al_empty))
            else begin
              $display("FAIL o_lk_dat=%h expected %h, i_al_empty=%h",
                       o_lk_dat, exp_v[DAT_W-1:0], i_al_empty);
              err_cnt++;
            end
          if (exp_v[DAT_W]) begin
            push_occ--;
          end else begin
            pop_occ--;
          end
        end
        tb_active[e] = 1'b1;
        wb_cnt[e]    = 1 + int'(rand_bits(3));
      end
      // The DUT drops its active bit at the next edge
      if (i_wrbk_vld) begin
        tb_active[i_wrbk_engid] = 1'b0;
      end
    end
  end

  // Engines, allocator and writeback return, 1 ns after the edge
  task automatic drive_cycle(input int mode, input int cyc, input int busy_hold,
                             input int empty_hold, input logic rnd_stall);
    int wb_e;
    wb_e = -1;
    for (int k = 0; k < ENGS; k++) begin
      if (mode == M_IDLE) begin
        i_cmd_opcode[k] = lfsr_bit() ? stk_cmd_pkg::OP_RSVD : stk_cmd_pkg::OP_NOP;
      end else if (!holding[k] || ack_seen[k]) begin
        if (cmd_left[k] > 0) begin
          if (mode == M_MIX) begin
            i_cmd_opcode[k] = lfsr_bit() ? stk_cmd_pkg::OP_POP : stk_cmd_pkg::OP_PUSH;
            // Push and pop queues drain independently
            // Stay with the opcode of earlier unissued commands
            if (pend_q[k].size() > 0) begin
              i_cmd_opcode[k] = stk_cmd_pkg::opcode_t'(pend_q[k][0][DAT_W+1:DAT_W]);
            end
          end else begin
            i_cmd_opcode[k] = (mode == M_PUSH) ? stk_cmd_pkg::OP_PUSH : stk_cmd_pkg::OP_POP;
          end
          if (i_cmd_opcode[k] == stk_cmd_pkg::OP_PUSH) begin
            i_cmd_dat[k] = rand_bits(DAT_W);
          end else begin
            i_cmd_dat[k] = '0;
          end
          cmd_left[k]--;
          holding[k] = 1'b1;
        end else begin
          i_cmd_opcode[k] = stk_cmd_pkg::OP_NOP;
          i_cmd_dat[k]    = '0;
          holding[k]      = 1'b0;
        end
      end
      ack_seen[k] = 1'b0;
      // One writeback per cycle, lowest ready engine first
      if (wb_cnt[k] == 0 && wb_e < 0) begin
        wb_e      = k;
        wb_cnt[k] = -1;
      end else if (wb_cnt[k] > 0) begin
        wb_cnt[k]--;
      end
    end
    if (cyc < busy_hold) begin
      i_al_busy = 1'b1;
    end else if (rnd_stall) begin
      i_al_busy = lfsr_bit() & lfsr_bit();
    end else begin
      i_al_busy = 1'b0;
    end
    if (cyc < empty_hold) begin
      i_al_empty = 1'b1;
    end else if (rnd_stall) begin
      i_al_empty = lfsr_bit() & lfsr_bit();
    end else begin
      i_al_empty = 1'b0;
    end
    i_wrbk_vld   = (wb_e >= 0);
    i_wrbk_engid = stk_cmd_pkg::engid_t'((wb_e < 0) ? 0 : wb_e);
  endtask

  // Runs until every command has issued and written back
  task automatic run_test(input string name, input int mode, input int mask, input int n_cmd,
                          input int min_cyc, input int busy_hold, input int empty_hold,
                          input logic rnd_stall);
    int cyc;
    int err0;
    int iss0;
    err0 = err_cnt;
    iss0 = issue_cnt;
    cyc  = 0;
    for (int k = 0; k < ENGS; k++) begin
      cmd_left[k] = mask[k] ? n_cmd : 0;
    end
    do begin
      @(posedge clk);
      #1;
      drive_cycle(mode, cyc, busy_hold, empty_hold, rnd_stall);
      cyc++;
    end while (cyc < min_cyc || !all_idle());
    $display("test %-14s cycles %0d issues %0d errors %0d",
             name, cyc, issue_cnt - iss0, err_cnt - err0);
  endtask

  initial begin : watchdog
    repeat (RST_CYC + TOTAL_CMD * WDOG_MULT) @(posedge clk);
    $display("timeout, commands still outstanding when the run was stopped");
    $display("Verification failed");
    $finish;
  end

  initial begin : main
    clk          = 1'b0;
    i_rst_n      = 1'b0;
    i_cmd_opcode = '0;
    i_cmd_dat    = '0;
    i_al_empty   = 1'b0;
    i_al_busy    = 1'b0;
    i_wrbk_vld   = 1'b0;
    i_wrbk_engid = '0;
    lfsr_q       = 16'd34;
    push_occ     = 0;
    pop_occ      = 0;
    tb_active    = '0;
    ack_seen     = '0;
    holding      = '0;
    err_cnt      = 0;
    ack_cnt      = 0;
    issue_cnt    = 0;
    for (int k = 0; k < ENGS; k++) begin
      cmd_left[k] = 0;
      wb_cnt[k]   = -1;
      wait_cnt[k] = 0;
    end
    repeat (RST_CYC) @(posedge clk);
    #1;
    i_rst_n = 1'b1;
    @(negedge clk);
    assert (o_cmd_ack == '0 && !o_lk_vld && !o_lk_dat_vld && !o_al_alloc)
      else begin
        $display("control outputs not low after reset");
        err_cnt++;
      end
    // NOP and reserved only, nothing may be acked or issued
    run_test("reset_idle", M_IDLE, ALL_ENG, 0, 20, 0, 0, 1'b0);
    // PUSH held back while the allocator has no line
    run_test("single_push", M_PUSH, 'h2, 1, 0, 0, 10, 1'b0);
    run_test("single_pop", M_POP, 'h4, 1, 0, 0, 0, 1'b0);
    run_test("one_in_flight", M_MIX, 'h9, 6, 0, 0, 0, 1'b0);
    run_test("random_all", M_MIX, ALL_ENG, 24, 0, 0, 0, 1'b1);
    // Busy long enough for both queues to fill
    run_test("backpressure", M_MIX, ALL_ENG, 6, 0, 24, 0, 1'b0);
    assert (ack_cnt == TOTAL_CMD && issue_cnt == TOTAL_CMD)
      else begin
        $display("acknowledged or issued command count differs from %0d", TOTAL_CMD);
        err_cnt++;
      end
    $display("tests 6, acks %0d, issues %0d, errors %0d", ack_cnt, issue_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : stk_pipe_ad_tb

// ==== filelist.f ====
+incdir+common
common/stk_cmd_pkg.sv
common/stk_issue_pkg.sv
common/stk_enq_if.sv
common/stk_head_if.sv
verilog/stk_rr_arb.sv
verilog/stk_cmd_queue.sv
admit/stk_admit.sv
issue/stk_issue.sv
verilog/stk_pipe_ad.sv
sim/stk_pipe_ad_sva.sv
sim/stk_pipe_ad_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module stk_pipe_ad_tb \
  -o stk_pipe_ad_sim || exit 1
out="$(./obj_dir/stk_pipe_ad_sim)"
echo "$out"
echo "$out" | grep -qx "Verification passed" && exit 0 || exit 1
